/* common/fscpu_defs.svh */
`ifndef FSCPU_DEFS_SVH
`define FSCPU_DEFS_SVH

// image column coordinate
`define IMG_WW 12

// one half of a 32-bit parameter word
`define PARAM_HALF_W 16

// image delay counter, full parameter word
`define IMG_DELAY_W 32

// motor speed word
`define SPEED_W 32

// motor step count
`define STEP_W 32

// correction table is indexed by edge distance, so one entry per column
`define TABLE_AW `IMG_WW

`endif

/* common/fscpu_pkg.sv */
`default_nettype none
`include "fscpu_defs.svh"

package fscpu_pkg;

	// host command codes
	typedef enum logic [31:0] {
		cmd_config     = 32'd0,
		cmd_move_left  = 32'd1,
		cmd_move_right = 32'd2,
		cmd_move_both  = 32'd3
	} req_cmd_e;

	typedef enum logic [3:0] {
		idle,
		plain_start,
		plain_run,
		img_wait,
		img_delay,
		img_lookup,
		img_start,
		img_run,
		finish
	} ctl_state_e;

	// 128-bit parameter word, word 3 at the top
	typedef struct packed {
		logic [`STEP_W-1:0]               step;
		logic [`SPEED_W-1:0]              speed;
		logic [`PARAM_HALF_W-`IMG_WW-1:0] tol_pad;
		logic [`IMG_WW-1:0]               img_tol;
		logic [`PARAM_HALF_W-`IMG_WW-1:0] dst_pad;
		logic [`IMG_WW-1:0]               img_dst;
		// word 0 doubles as the image delay on a config
		logic [`IMG_DELAY_W-4:0]          delay_hi;
		logic                             dep_img;
		logic                             dir_back;
		logic                             single_dir;
	} motor_req_t;

	typedef struct packed {
		logic                sel;
		logic                start;
		logic                stop;
		logic [`SPEED_W-1:0] speed;
		logic [`STEP_W-1:0]  step;
		logic                dir;
	} motor_cmd_t;

	// zpsign at the zero end, tpsign at the far end
	typedef struct packed {
		logic zpsign;
		logic tpsign;
		logic busy;
	} motor_status_t;

	typedef struct packed {
		logic               valid;
		logic [`IMG_WW-1:0] pos;
	} img_edge_t;

endpackage

`default_nettype wire

/* fscpu.f */
+incdir+common
common/fscpu_pkg.sv
source/step_table_ram.sv
motor_ctl/motor_ctl.sv
source/fscpu.sv
tests/fscpu_tb.sv

/* motor_ctl/motor_ctl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fscpu_defs.svh"

module motor_ctl #(
	parameter bit L2R = 1'b1
) (
	input  wire                            clk,
	input  wire                            resetn,
	input  wire                            run,
	input  wire  [`IMG_DELAY_W-1:0]        img_delay,
	input  wire  fscpu_pkg::motor_req_t    req,
	input  wire                            img_pulse,
	input  wire  fscpu_pkg::img_edge_t     img_edge,
	input  wire  fscpu_pkg::motor_status_t status,
	output fscpu_pkg::motor_cmd_t          cmd,
	output logic [`TABLE_AW-1:0]           rd_addr,
	input  wire  [`STEP_W-1:0]             rd_data,
	output logic                           done,
	output logic [1:0]                     err
);
	import fscpu_pkg::*;

	ctl_state_e state;
	logic [`IMG_DELAY_W-1:0] delay_cnt;
	logic busy_seen;
	logic moved;
	logic first_dir;
	logic start_q;
	logic stop_q;
	logic [`SPEED_W-1:0] speed_q;
	logic [`STEP_W-1:0] step_q;
	logic dir_q;

	logic smp_valid;
	logic [`IMG_WW-1:0] smp_diff;
	logic smp_dir;

	logic pos_gt;
	logic [`IMG_WW-1:0] diff;
	logic need_dir;
	logic sample;
	logic limit_hit;
	logic move_end;

	// distance and direction from the live edge
	assign pos_gt = img_edge.pos > req.img_dst;
	assign diff = pos_gt ? img_edge.pos - req.img_dst : req.img_dst - img_edge.pos;
	// right motor is mounted the other way round
	assign need_dir = pos_gt ~^ L2R;

	assign sample = (state == fscpu_pkg::img_delay) && (delay_cnt == img_delay);
	assign limit_hit = dir_q ? status.tpsign : status.zpsign;
	assign move_end = busy_seen && !status.busy;

	assign cmd = '{sel: run, start: start_q, stop: stop_q,
		speed: speed_q, step: step_q, dir: dir_q};
	assign done = (state == finish);

	// edge capture and table address, read data is back one cycle later
	always_ff @(posedge clk) begin
		if (sample) begin
			smp_valid <= img_edge.valid;
			smp_diff <= diff;
			smp_dir <= need_dir;
			rd_addr <= diff;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn || !run) begin
			state <= idle;
			delay_cnt <= '0;
			busy_seen <= 1'b0;
			moved <= 1'b0;
			first_dir <= 1'b0;
			start_q <= 1'b0;
			stop_q <= 1'b0;
			speed_q <= '0;
			step_q <= '0;
			dir_q <= 1'b0;
			err <= '0;
		end else begin
			start_q <= 1'b0;
			stop_q <= 1'b0;
			case (state)
				idle: begin
					state <= req.dep_img ? img_wait : plain_start;
				end
				plain_start: begin
					start_q <= 1'b1;
					speed_q <= req.speed;
					step_q <= req.step;
					dir_q <= req.dir_back;
					busy_seen <= 1'b0;
					state <= plain_run;
				end
				plain_run, img_run: begin
					if (status.busy) begin
						busy_seen <= 1'b1;
					end
					if (limit_hit) begin
						stop_q <= 1'b1;
						err[0] <= 1'b1;
						state <= finish;
					end else if (move_end) begin
						speed_q <= '0;
						step_q <= '0;
						dir_q <= 1'b0;
						// image moves go back for the next frame
						state <= (state == plain_run) ? finish : img_wait;
					end
				end
				img_wait: begin
					if (img_pulse) begin
						delay_cnt <= '0;
						state <= fscpu_pkg::img_delay;
					end
				end
				fscpu_pkg::img_delay: begin
					if (sample) begin
						state <= img_lookup;
					end else begin
						delay_cnt <= delay_cnt + 1'b1;
					end
				end
				img_lookup: begin
					if (!smp_valid) begin
						err[1] <= 1'b1;
						state <= finish;
					end else if (smp_diff <= req.img_tol) begin
						state <= finish;
					end else if (req.single_dir && moved && (smp_dir != first_dir)) begin
						// overshoot on a one-way approach, stop here
						state <= finish;
					end else begin
						state <= img_start;
					end
				end
				img_start: begin
					start_q <= 1'b1;
					speed_q <= req.speed;
					step_q <= rd_data;
					dir_q <= smp_dir;
					busy_seen <= 1'b0;
					moved <= 1'b1;
					if (!moved) begin
						first_dir <= smp_dir;
					end
					state <= img_run;
				end
				finish: begin
					// held until run drops
					state <= finish;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	a_start_stop: assert property (@(posedge clk) disable iff (!resetn)
		!(cmd.start && cmd.stop));

	a_start_run: assert property (@(posedge clk) disable iff (!resetn)
		cmd.start |-> run);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the fscpu testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module fscpu_tb \
	-f fscpu.f -o fscpu_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/fscpu_sim > sim.log 2>&1 \
	|| { echo "simulation stopped with an error, see sim.log"; exit 1; }

grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL, no result line in sim.log"; exit 1; }
echo "PASS"

/* source/fscpu.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fscpu_defs.svh"

module fscpu (
	input  wire                           clk,
	input  wire                           resetn,
	input  wire                           bpm_init,
	input  wire                           bpm_wr_en,
	input  wire  [`STEP_W-1:0]            bpm_data,
	output wire  [`TABLE_AW:0]            bpm_size,
	input  wire                           req_en,
	input  wire  fscpu_pkg::req_cmd_e     req_cmd,
	input  wire  fscpu_pkg::motor_req_t   req_param,
	output logic                          req_done,
	output logic [3:0]                    req_err,
	input  wire                           ana_done,
	input  wire  fscpu_pkg::img_edge_t    lft_edge,
	input  wire  fscpu_pkg::img_edge_t    rt_edge,
	input  wire  fscpu_pkg::motor_status_t ml_status,
	input  wire  fscpu_pkg::motor_status_t mr_status,
	output wire  fscpu_pkg::motor_cmd_t   ml_cmd,
	output wire  fscpu_pkg::motor_cmd_t   mr_cmd
);
	import fscpu_pkg::*;

	localparam int LFT = 0;
	localparam int RT = 1;

	logic [1:0] oper_bmp;
	wire  [1:0] done_bmp;
	wire  [1:0] lft_err;
	wire  [1:0] rt_err;
	logic [`IMG_DELAY_W-1:0] cfg_img_delay;
	motor_req_t req_q;
	wire  [`TABLE_AW-1:0] addr_a;
	wire  [`TABLE_AW-1:0] addr_b;
	wire  [`STEP_W-1:0] q_a;
	wire  [`STEP_W-1:0] q_b;
	logic cmd_active;
	logic all_done;
	logic req_accept;
	logic is_move;

	assign cmd_active = |oper_bmp;
	assign all_done = cmd_active && ((done_bmp & oper_bmp) == oper_bmp);
	// requests during a running command are dropped
	assign req_accept = req_en && !cmd_active;
	assign is_move = req_cmd inside {cmd_move_left, cmd_move_right, cmd_move_both};

	always_ff @(posedge clk) begin
		if (!resetn) begin
			oper_bmp <= '0;
			cfg_img_delay <= '0;
		end else if (all_done) begin
			// controllers drop to idle while run is low
			oper_bmp <= '0;
		end else if (req_accept) begin
			case (req_cmd)
				cmd_config: begin
					oper_bmp <= '0;
					cfg_img_delay <= {req_param.delay_hi, req_param.dep_img,
						req_param.dir_back, req_param.single_dir};
				end
				cmd_move_left:  oper_bmp <= 2'b01;
				cmd_move_right: oper_bmp <= 2'b10;
				cmd_move_both:  oper_bmp <= 2'b11;
				default:        oper_bmp <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_accept && is_move) begin
			req_q <= req_param;
		end
	end

	// config and unknown commands complete at once
	always_ff @(posedge clk) begin
		if (!resetn) begin
			req_done <= 1'b0;
			req_err <= '0;
		end else if (req_accept) begin
			req_done <= !is_move;
			req_err <= '0;
		end else if (all_done) begin
			req_done <= 1'b1;
			req_err <= {rt_err[1], lft_err[1], rt_err[0], lft_err[0]};
		end
	end

	step_table_ram step_table (
		.clk     (clk),
		.resetn  (resetn),
		.init    (bpm_init),
		.wr_en   (bpm_wr_en),
		.wr_data (bpm_data),
		.size    (bpm_size),
		.addr_a  (addr_a),
		.q_a     (q_a),
		.addr_b  (addr_b),
		.q_b     (q_b)
	);

	motor_ctl #(
		.L2R (1'b1)
	) lft_motor_ctl (
		.clk       (clk),
		.resetn    (resetn),
		.run       (oper_bmp[LFT]),
		.img_delay (cfg_img_delay),
		.req       (req_q),
		.img_pulse (ana_done),
		.img_edge  (lft_edge),
		.status    (ml_status),
		.cmd       (ml_cmd),
		.rd_addr   (addr_a),
		.rd_data   (q_a),
		.done      (done_bmp[LFT]),
		.err       (lft_err)
	);

	motor_ctl #(
		.L2R (1'b0)
	) rt_motor_ctl (
		.clk       (clk),
		.resetn    (resetn),
		.run       (oper_bmp[RT]),
		.img_delay (cfg_img_delay),
		.req       (req_q),
		.img_pulse (ana_done),
		.img_edge  (rt_edge),
		.status    (mr_status),
		.cmd       (mr_cmd),
		.rd_addr   (addr_b),
		.rd_data   (q_b),
		.done      (done_bmp[RT]),
		.err       (rt_err)
	);

	a_done_after_all: assert property (@(posedge clk) disable iff (!resetn)
		$rose(req_done) |-> $past((oper_bmp & ~done_bmp) == 2'b00));

endmodule

`default_nettype wire

/* source/step_table_ram.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fscpu_defs.svh"

module step_table_ram (
	input  wire                  clk,
	input  wire                  resetn,
	input  wire                  init,
	input  wire                  wr_en,
	input  wire  [`STEP_W-1:0]   wr_data,
	output logic [`TABLE_AW:0]   size,
	input  wire  [`TABLE_AW-1:0] addr_a,
	output logic [`STEP_W-1:0]   q_a,
	input  wire  [`TABLE_AW-1:0] addr_b,
	output logic [`STEP_W-1:0]   q_b
);
	localparam int unsigned DEPTH = 1 << `TABLE_AW;

	logic [`STEP_W-1:0] mem [DEPTH];
	logic full;
	logic wr_ok;
	logic [`TABLE_AW-1:0] last_addr;
	logic [`TABLE_AW-1:0] rd_a;
	logic [`TABLE_AW-1:0] rd_b;

	// depth is a power of two, so the top bit marks full
	assign full = size[`TABLE_AW];
	assign wr_ok = wr_en && !init && !full;
	assign last_addr = (size == '0) ? '0 : size[`TABLE_AW-1:0] - 1'b1;

	// beyond the fill count, read the last entry written
	assign rd_a = ({1'b0, addr_a} < size) ? addr_a : last_addr;
	assign rd_b = ({1'b0, addr_b} < size) ? addr_b : last_addr;

	always_ff @(posedge clk) begin
		if (!resetn || init) begin
			size <= '0;
		end else if (wr_ok) begin
			size <= size + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[size[`TABLE_AW-1:0]] <= wr_data;
		end
		q_a <= mem[rd_a];
		q_b <= mem[rd_b];
	end

	a_no_overfill: assert property (@(posedge clk) disable iff (!resetn)
		(wr_en && !init) |-> !full);

endmodule

`default_nettype wire

/* tests/fscpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fscpu_defs.svh"

module motor_model #(
	parameter int EXTRA = 0
) (
	input  wire                         clk,
	input  wire                         resetn,
	input  wire  fscpu_pkg::motor_cmd_t cmd,
	output wire                         busy
);
	logic level = 1'b0;
	int lead = 0;
	int hold = 0;

	assign busy = level;

	// busy two cycles after start, length set by the low step bits
	always @(posedge clk) begin
		#5;
		if (!resetn || cmd.stop) begin
			level = 1'b0;
			lead = 0;
			hold = 0;
		end else if (cmd.start) begin
			lead = 2;
			hold = int'(cmd.step[3:0]) + 1 + EXTRA;
		end else if (lead > 0) begin
			lead = lead - 1;
			level = (lead == 0);
		end else if (level) begin
			hold = hold - 1;
			level = (hold > 0);
		end
	end
endmodule

module fscpu_tb;
	import fscpu_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int FILL_CYCLES = 80;
	localparam int PLAIN_CYCLES = 3 * 60;
	localparam int BOTH_CYCLES = 100;
	localparam int IMAGE_CYCLES = 2 * 150;
	localparam int FAULT_CYCLES = 3 * 60;
	localparam int CYCLE_LIMIT = RESET_CYCLES + FILL_CYCLES + PLAIN_CYCLES + BOTH_CYCLES
		+ IMAGE_CYCLES + FAULT_CYCLES;
	localparam int FILL = 24;
	localparam int PULSE_WAIT = 40;
	localparam int DONE_WAIT = 80;
	localparam int MOVE_WAIT = 60;
	localparam int SIZE_W = `TABLE_AW + 1;
	localparam int IMG_W = `IMG_WW;

	logic clk;
	logic resetn;
	logic bpm_init;
	logic bpm_wr_en;
	logic [`STEP_W-1:0] bpm_data;
	logic [`TABLE_AW:0] bpm_size;
	logic req_en;
	req_cmd_e req_cmd;
	motor_req_t req_param;
	logic req_done;
	logic [3:0] req_err;
	logic ana_done;
	img_edge_t lft_edge;
	img_edge_t rt_edge;
	logic ml_zp;
	logic ml_tp;
	logic mr_zp;
	logic mr_tp;
	wire ml_busy;
	wire mr_busy;
	motor_status_t ml_status;
	motor_status_t mr_status;
	motor_cmd_t ml_cmd;
	motor_cmd_t mr_cmd;

	integer seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic [`STEP_W-1:0] tbl [FILL];
	int frames[$];

	assign ml_status = '{zpsign: ml_zp, tpsign: ml_tp, busy: ml_busy};
	assign mr_status = '{zpsign: mr_zp, tpsign: mr_tp, busy: mr_busy};

	fscpu dut (
		.clk       (clk),
		.resetn    (resetn),
		.bpm_init  (bpm_init),
		.bpm_wr_en (bpm_wr_en),
		.bpm_data  (bpm_data),
		.bpm_size  (bpm_size),
		.req_en    (req_en),
		.req_cmd   (req_cmd),
		.req_param (req_param),
		.req_done  (req_done),
		.req_err   (req_err),
		.ana_done  (ana_done),
		.lft_edge  (lft_edge),
		.rt_edge   (rt_edge),
		.ml_status (ml_status),
		.mr_status (mr_status),
		.ml_cmd    (ml_cmd),
		.mr_cmd    (mr_cmd)
	);

	// right motor runs a little longer so the two finish apart
	motor_model #(.EXTRA(0)) lft_motor (.clk(clk), .resetn(resetn), .cmd(ml_cmd), .busy(ml_busy));
	motor_model #(.EXTRA(5)) rt_motor (.clk(clk), .resetn(resetn), .cmd(mr_cmd), .busy(mr_busy));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d errors so far", cycles, errors);
			$display("Done: errors found");
			$finish;
		end
	end

	task tick;
		@(posedge clk);
		#5;
	endtask

	function motor_cmd_t cmd_of(input bit right);
		return right ? mr_cmd : ml_cmd;
	endfunction

	task check_cmd(input string name, input motor_cmd_t got, input motor_cmd_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task check_status(input logic exp_done, input logic [3:0] exp_err);
		checks++;
		if (req_done !== exp_done) begin
			errors++;
			$display("** Error at %0t: req_done expected %b got %b", $time, exp_done, req_done);
		end
		if (req_err !== exp_err) begin
			errors++;
			$display("** Error at %0t: req_err expected %b got %b", $time, exp_err, req_err);
		end
	endtask

	task check_size(input logic [`TABLE_AW:0] exp);
		checks++;
		if (bpm_size !== exp) begin
			errors++;
			$display("** Error at %0t: bpm_size expected %0d got %0d", $time, exp, bpm_size);
		end
	endtask

	function motor_cmd_t move_cmd(input logic [`SPEED_W-1:0] speed,
		input logic [`STEP_W-1:0] step, input logic dir);
		motor_cmd_t c;
		c = '0;
		c.sel = 1'b1;
		c.start = 1'b1;
		c.speed = speed;
		c.step = step;
		c.dir = dir;
		return c;
	endfunction

	// distances past the fill count read the last entry
	function logic [`STEP_W-1:0] table_entry(input int diff);
		return (diff < FILL) ? tbl[diff] : tbl[FILL-1];
	endfunction

	function logic move_dir(input bit right, input int pos, input int dst);
		logic gt;
		gt = pos > dst;
		return right ? !gt : gt;
	endfunction

	task wait_cmd_pulse(input bit right, input bit stop_pulse, output bit seen);
		int i;
		motor_cmd_t c;
		seen = 1'b0;
		for (i = 0; i < PULSE_WAIT && !seen; i++) begin
			@(negedge clk);
			c = cmd_of(right);
			seen = stop_pulse ? c.stop : c.start;
		end
		if (!seen) begin
			errors++;
			$display("no %s pulse on %s within %0d cycles", stop_pulse ? "stop" : "start",
				right ? "mr_cmd" : "ml_cmd", PULSE_WAIT);
		end
	endtask

	task wait_done;
		int i;
		for (i = 0; i < DONE_WAIT && !req_done; i++) begin
			@(negedge clk);
			if (ml_cmd.start || mr_cmd.start) begin
				errors++;
				$display("unexpected start pulse at %0t while waiting for req_done", $time);
			end
		end
		if (!req_done) begin
			errors++;
			$display("req_done did not rise within %0d cycles", DONE_WAIT);
		end
	endtask

	task wait_move_end(input bit right);
		int i;
		motor_cmd_t c;
		c = cmd_of(right);
		for (i = 0; i < MOVE_WAIT && c.speed != '0; i++) begin
			@(negedge clk);
			c = cmd_of(right);
		end
		if (c.speed != '0) begin
			errors++;
			$display("move on %s did not end within %0d cycles",
				right ? "mr_cmd" : "ml_cmd", MOVE_WAIT);
		end
	endtask

	task send_req(input req_cmd_e c, input motor_req_t p);
		tick;
		req_cmd = c;
		req_param = p;
		req_en = 1'b1;
		tick;
		req_en = 1'b0;
	endtask

	task configure(input int delay);
		motor_req_t p;
		p = '0;
		p[31:0] = delay;
		send_req(cmd_config, p);
		@(negedge clk);
		check_status(1'b1, 4'b0000);
	endtask

	task fill_table(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			tick;
			tbl[i] = ($random(seed) & 32'h3f) + 1;
			bpm_data = tbl[i];
			bpm_wr_en = 1'b1;
			@(negedge clk);
			check_size(SIZE_W'(i));
		end
		tick;
		bpm_wr_en = 1'b0;
		@(negedge clk);
		check_size(SIZE_W'(n));
	endtask

	task make_plain_req(output motor_req_t p, input logic dir);
		p = '0;
		p.speed = $random(seed) | 1;
		p.step = ($random(seed) & 32'hff) + 1;
		p.dir_back = dir;
	endtask

	task set_limits(input bit right, input logic zp, input logic tp);
		if (right) begin
			mr_zp = zp;
			mr_tp = tp;
		end else begin
			ml_zp = zp;
			ml_tp = tp;
		end
	endtask

	task plain_move(input bit right, input motor_req_t p);
		bit seen;
		send_req(right ? cmd_move_right : cmd_move_left, p);
		@(negedge clk);
		check_status(1'b0, 4'b0000);
		wait_cmd_pulse(right, 1'b0, seen);
		if (seen) begin
			check_cmd(right ? "mr_cmd" : "ml_cmd", cmd_of(right),
				move_cmd(p.speed, p.step, p.dir_back));
			check_cmd(right ? "ml_cmd" : "mr_cmd", cmd_of(!right), '0);
		end
		wait_done;
		check_status(1'b1, 4'b0000);
		check_cmd(right ? "mr_cmd" : "ml_cmd", cmd_of(right), '0);
	endtask

	task image_frame(input bit right, input logic valid, input logic [`IMG_WW-1:0] pos,
		input bit moves, input motor_cmd_t exp);
		bit seen;
		img_edge_t e;
		e.valid = valid;
		e.pos = pos;
		tick;
		if (right) begin
			rt_edge = e;
		end else begin
			lft_edge = e;
		end
		ana_done = 1'b1;
		tick;
		ana_done = 1'b0;
		if (moves) begin
			wait_cmd_pulse(right, 1'b0, seen);
			if (seen) begin
				check_cmd(right ? "mr_cmd" : "ml_cmd", cmd_of(right), exp);
			end
			wait_move_end(right);
		end else begin
			wait_done;
		end
	endtask

	task image_run(input bit right, input motor_req_t p);
		int i;
		int pos;
		int diff;
		logic d;
		logic first_d;
		bit first_set;
		bit moves;
		send_req(right ? cmd_move_right : cmd_move_left, p);
		@(negedge clk);
		check_status(1'b0, 4'b0000);
		first_set = 1'b0;
		first_d = 1'b0;
		for (i = 0; i < frames.size(); i++) begin
			pos = frames[i];
			diff = (pos > int'(p.img_dst)) ? pos - int'(p.img_dst) : int'(p.img_dst) - pos;
			d = move_dir(right, pos, int'(p.img_dst));
			// one-way approach stops at the first reversal
			moves = (diff > int'(p.img_tol)) && !(p.single_dir && first_set && d != first_d);
			if (moves && !first_set) begin
				first_set = 1'b1;
				first_d = d;
			end
			image_frame(right, 1'b1, IMG_W'(pos), moves, move_cmd(p.speed, table_entry(diff), d));
		end
		check_status(1'b1, 4'b0000);
	endtask

	// a limit only counts at the end the motor is heading for
	task limit_fault(input bit right, input logic dir);
		motor_req_t p;
		motor_cmd_t exp;
		motor_cmd_t c;
		bit seen;
		int i;
		make_plain_req(p, dir);
		p.step = 32'h0f;
		send_req(right ? cmd_move_right : cmd_move_left, p);
		@(negedge clk);
		check_status(1'b0, 4'b0000);
		wait_cmd_pulse(right, 1'b0, seen);
		tick;
		set_limits(right, dir, !dir);
		for (i = 0; i < 3; i++) begin
			@(negedge clk);
			c = cmd_of(right);
			if (c.stop) begin
				errors++;
				$display("stop pulse at %0t from the limit behind the move", $time);
			end
		end
		tick;
		set_limits(right, !dir, dir);
		wait_cmd_pulse(right, 1'b1, seen);
		exp = move_cmd(p.speed, p.step, dir);
		exp.start = 1'b0;
		exp.stop = 1'b1;
		if (seen) begin
			check_cmd(right ? "mr_cmd" : "ml_cmd", cmd_of(right), exp);
		end
		wait_done;
		check_status(1'b1, right ? 4'b0010 : 4'b0001);
		tick;
		set_limits(right, 1'b0, 1'b0);
	endtask

	task test_table_fill;
		fill_table(3);
		tick;
		bpm_init = 1'b1;
		tick;
		bpm_init = 1'b0;
		@(negedge clk);
		check_size('0);
		fill_table(FILL);
		configure(2);
	endtask

	task test_both_motors;
		motor_req_t p;
		motor_cmd_t exp;
		bit seen;
		bit lft_fin;
		bit rt_fin;
		int i;
		make_plain_req(p, 1'b0);
		exp = move_cmd(p.speed, p.step, 1'b0);
		send_req(cmd_move_both, p);
		@(negedge clk);
		check_status(1'b0, 4'b0000);
		wait_cmd_pulse(1'b0, 1'b0, seen);
		if (seen) begin
			check_cmd("ml_cmd", ml_cmd, exp);
			check_cmd("mr_cmd", mr_cmd, exp);
		end
		lft_fin = 1'b0;
		rt_fin = 1'b0;
		for (i = 0; i < DONE_WAIT && !req_done; i++) begin
			@(negedge clk);
			if (req_done && !(lft_fin && rt_fin)) begin
				errors++;
				$display("req_done rose at %0t before both motors finished", $time);
			end
			lft_fin = lft_fin || (ml_cmd.speed == '0);
			rt_fin = rt_fin || (mr_cmd.speed == '0);
		end
		if (!req_done) begin
			errors++;
			$display("req_done did not rise after the two-motor move");
		end
		check_status(1'b1, 4'b0000);
		// next request has to clear req_done
		make_plain_req(p, 1'b1);
		plain_move(1'b1, p);
	endtask

	task test_image_moves;
		motor_req_t p;
		p = '0;
		p.dep_img = 1'b1;
		p.img_dst = 12'd100;
		p.img_tol = 12'd2;
		p.speed = 32'd1200;
		frames = {110, 94, 101};
		image_run(1'b1, p);
		p.img_dst = 12'd200;
		p.img_tol = 12'd1;
		p.single_dir = 1'b1;
		p.speed = 32'd800;
		frames = {240, 230, 190};
		image_run(1'b0, p);
	endtask

	task test_faults;
		motor_req_t p;
		limit_fault(1'b0, 1'b1);
		limit_fault(1'b1, 1'b0);
		p = '0;
		p.dep_img = 1'b1;
		p.img_dst = 12'd50;
		p.img_tol = 12'd1;
		p.speed = 32'd1;
		send_req(cmd_move_right, p);
		@(negedge clk);
		check_status(1'b0, 4'b0000);
		image_frame(1'b1, 1'b0, 12'd50, 1'b0, '0);
		check_status(1'b1, 4'b1000);
	endtask

	initial begin
		motor_req_t p;
		seed = 32'hc92d7be1;
		resetn = 1'b0;
		bpm_init = 1'b0;
		bpm_wr_en = 1'b0;
		bpm_data = '0;
		req_en = 1'b0;
		req_cmd = cmd_config;
		req_param = '0;
		ana_done = 1'b0;
		lft_edge = '0;
		rt_edge = '0;
		ml_zp = 1'b0;
		ml_tp = 1'b0;
		mr_zp = 1'b0;
		mr_tp = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		resetn = 1'b1;
		@(negedge clk);
		check_status(1'b0, 4'b0000);
		check_size('0);
		check_cmd("ml_cmd", ml_cmd, '0);
		check_cmd("mr_cmd", mr_cmd, '0);
		test_table_fill;
		make_plain_req(p, 1'b1);
		plain_move(1'b0, p);
		test_both_motors;
		test_image_moves;
		test_faults;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
